// ==== Makefile ====
# Verilator simulation of the SoC testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f src.f --top-module tb_soc_top -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/bus_decoder.sv ====
`default_nettype none

module bus_decoder (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              cyc,
  input  logic              stb,
  input  soc_pkg::bus_addr_t adr,
  input  logic              sram_ack,
  input  soc_pkg::bus_data_t sram_dat,
  input  logic              regs_ack,
  output logic              sram_stb,
  output logic              regs_vga_stb,
  output logic              regs_dma_stb,
  output soc_pkg::bus_data_t dat_r,
  output logic              ack
);

  import soc_pkg::*;

  logic      req;                           // live request from the master
  logic      hit_sram;
  logic      hit_vga;
  logic      hit_dma;
  logic      hit_none;                      // unmapped range
  logic      void_ack;                      // ack we generate ourselves

  assign req      = cyc && stb;
  assign hit_sram = (adr[31:16] == win_sram);
  assign hit_vga  = (adr[31:16] == win_vga);
  assign hit_dma  = (adr[31:16] == win_dma);
  assign hit_none = !(hit_sram || hit_vga || hit_dma);

  // one strobe per window, targets never look at adr[31:16]
  assign sram_stb     = req && hit_sram;
  assign regs_vga_stb = req && hit_vga;
  assign regs_dma_stb = req && hit_dma;

  // unmapped: single-cycle ack pulse, no write side effect
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      void_ack <= 1'b0;
    end else begin
      void_ack <= req && hit_none && !void_ack; // master drops stb after ack
    end
  end

  // return path
  always_comb begin
    if (hit_sram) begin
      ack   = sram_ack;
      dat_r = sram_dat;
    end else if (hit_vga || hit_dma) begin
      ack   = regs_ack;                     // dma window may stall here
      dat_r = '0;                           // register windows read as zero
    end else begin
      ack   = void_ack;
      dat_r = '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/main_sram.sv ====
`default_nettype none

module main_sram (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               stb,
  input  logic               we,
  input  soc_pkg::sram_addr_t word,
  input  soc_pkg::bus_data_t  dat_w,
  input  soc_pkg::bus_sel_t   sel,
  output soc_pkg::bus_data_t  dat_r,
  output logic               ack
);

  import soc_pkg::*;

  bus_data_t mem [sram_words];              // 512 x 32
  logic      take;                          // first cycle of an access

  assign take = stb && !ack;

  // byte lane writes, registered read
  always_ff @(posedge clk) begin
    if (take && we) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          mem[word][8*b +: 8] <= dat_w[8*b +: 8];
        end
      end
    end
    if (take) begin
      dat_r <= mem[word];                   // old data on a write, unused then
    end
  end

  // ack one cycle after stb, reads and writes alike
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack <= 1'b0;
    end else begin
      ack <= take;
    end
  end

endmodule

`default_nettype wire

// ==== design/page_copy_engine.sv ====
`default_nettype none

module page_copy_engine (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           blanking,
  input  logic           dma_go,
  input  soc_pkg::page_t dma_src,
  input  soc_pkg::page_t dma_dst,
  input  soc_pkg::page_t dma_len,
  input  logic           rd_ack,
  input  logic           wr_ack,
  output logic           dma_done,
  output logic           block_vga,
  output logic           dma_active,
  output logic           rd_req,
  output soc_pkg::page_t rd_page,
  output logic           rd_buf,
  output logic           wr_req,
  output soc_pkg::page_t wr_page,
  output logic           wr_buf
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    st_idle,                                // waiting for go and blanking
    st_wait_low,                            // both acks must be low
    st_wait_ack,                            // requests out
    st_done                                 // done high until go drops
  } state_t;

  state_t      state;
  logic        blank_s1;                    // two-flop synchroniser
  logic        blank_s2;
  logic        blank_q;                     // previous synced value
  logic        blank_rise;
  logic        busy;                        // copy in progress
  page_count_t count;                       // steps completed
  page_count_t count_end;                   // len + 1 steps in total
  logic        acks_low;
  logic        acks_high;

  assign blank_rise = blank_s2 && !blank_q;
  assign count_end  = {1'b0, dma_len} + 17'd1;
  assign acks_low   = !rd_ack && !wr_ack;
  assign acks_high  = rd_ack && (wr_ack || !wr_req); // step 0 has no write

  assign block_vga  = busy;                 // display held off for the whole copy
  assign dma_active = busy;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      blank_s1 <= 1'b0;
      blank_s2 <= 1'b0;
      blank_q  <= 1'b0;
    end else begin
      blank_s1 <= blanking;
      blank_s2 <= blank_s1;
      blank_q  <= blank_s2;
    end
  end

  // step sequencer
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= st_idle;
      busy     <= 1'b0;
      dma_done <= 1'b0;
      rd_req   <= 1'b0;
      wr_req   <= 1'b0;
      count    <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (dma_go && !dma_done && blank_rise) begin
            busy  <= 1'b1;
            count <= '0;
            state <= st_wait_low;
          end
        end
        st_wait_low: begin
          if (acks_low) begin
            if (count == count_end) begin
              busy     <= 1'b0;          // last ack gone, release display
              dma_done <= 1'b1;
              state    <= st_done;
            end else begin
              rd_req <= 1'b1;
              wr_req <= (count != '0);   // write trails read by one page
              state  <= st_wait_ack;
            end
          end
        end
        st_wait_ack: begin
          if (acks_high) begin
            rd_req <= 1'b0;
            wr_req <= 1'b0;
            count  <= count + 17'd1;
            state  <= st_wait_low;
          end
        end
        st_done: begin
          if (!dma_go) begin
            dma_done <= 1'b0;            // phase 4 of the go/done handshake
            state    <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // page numbers and buffer selects, stable while req is high
  always_ff @(posedge clk) begin
    if (state == st_idle && dma_go && !dma_done && blank_rise) begin
      rd_page <= dma_src;
      rd_buf  <= 1'b0;
      wr_page <= dma_dst - 16'd1;        // first write lands on dst
      wr_buf  <= 1'b1;
    end else if (state == st_wait_ack && acks_high) begin
      rd_page <= rd_page + 16'd1;
      rd_buf  <= !rd_buf;                // ping-pong
      wr_page <= wr_page + 16'd1;
      wr_buf  <= !wr_buf;
    end
  end

endmodule

`default_nettype wire

// ==== design/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  // bus side
  typedef logic [31:0] bus_addr_t;          // byte address
  typedef logic [31:0] bus_data_t;          // read and write data
  typedef logic [3:0]  bus_sel_t;           // one bit per byte lane

  // page copy side
  typedef logic [15:0] page_t;              // page number at a memory controller
  typedef logic [16:0] page_count_t;        // one wider than page_t, len + 1 fits

  // display side
  typedef logic [1:0]  vga_mode_t;
  typedef logic [11:0] line_base_t;

  localparam int sram_words = 512;          // 2 KiB of main memory
  typedef logic [$clog2(sram_words)-1:0] sram_addr_t; // word index, adr[10:2]

  // windows, compared against adr[31:16]
  localparam logic [15:0] win_sram = 16'h0200;
  localparam logic [15:0] win_vga  = 16'h0204;
  localparam logic [15:0] win_dma  = 16'h0205;

  // word offsets inside a window, adr[3:2]
  localparam logic [1:0] reg_vga_mode  = 2'd0;
  localparam logic [1:0] reg_line_base = 2'd1;
  localparam logic [1:0] reg_dma_src   = 2'd0;
  localparam logic [1:0] reg_dma_dst   = 2'd1;
  localparam logic [1:0] reg_dma_len   = 2'd2;
  localparam logic [1:0] reg_dma_go    = 2'd3;  // any write starts a copy

  localparam vga_mode_t vga_mode_reset = 2'd3;

endpackage

`default_nettype wire

// ==== design/soc_top.sv ====
`default_nettype none

module soc_top (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  soc_pkg::bus_addr_t  adr,
  input  soc_pkg::bus_data_t  dat_w,
  output soc_pkg::bus_data_t  dat_r,
  input  soc_pkg::bus_sel_t   sel,
  output logic                ack,
  input  logic                blanking,
  output soc_pkg::vga_mode_t  vga_mode,
  output soc_pkg::line_base_t line_base,
  output logic                block_vga,
  output logic                dma_active,
  output logic                rd_req,
  output soc_pkg::page_t      rd_page,
  output logic                rd_buf,
  input  logic                rd_ack,
  output logic                wr_req,
  output soc_pkg::page_t      wr_page,
  output logic                wr_buf,
  input  logic                wr_ack
);

  import soc_pkg::*;

  logic      sram_stb;
  logic      sram_ack;
  bus_data_t sram_dat;
  logic      regs_vga_stb;
  logic      regs_dma_stb;
  logic      regs_ack;
  page_t     dma_src;
  page_t     dma_dst;
  page_t     dma_len;
  logic      dma_go;
  logic      dma_done;

  bus_decoder u_bus_decoder (
    .clk          (clk),
    .reset_n      (reset_n),
    .cyc          (cyc),
    .stb          (stb),
    .adr          (adr),
    .sram_ack     (sram_ack),
    .sram_dat     (sram_dat),
    .regs_ack     (regs_ack),
    .sram_stb     (sram_stb),
    .regs_vga_stb (regs_vga_stb),
    .regs_dma_stb (regs_dma_stb),
    .dat_r        (dat_r),
    .ack          (ack)
  );

  main_sram u_main_sram (
    .clk     (clk),
    .reset_n (reset_n),
    .stb     (sram_stb),
    .we      (we),
    .word    (adr[10:2]),                  // word index inside the window
    .dat_w   (dat_w),
    .sel     (sel),
    .dat_r   (sram_dat),
    .ack     (sram_ack)
  );

  video_dma_regs u_video_dma_regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .vga_stb   (regs_vga_stb),
    .dma_stb   (regs_dma_stb),
    .we        (we),
    .offset    (adr[3:2]),
    .dat_w     (dat_w),
    .dma_done  (dma_done),
    .ack       (regs_ack),
    .vga_mode  (vga_mode),
    .line_base (line_base),
    .dma_src   (dma_src),
    .dma_dst   (dma_dst),
    .dma_len   (dma_len),
    .dma_go    (dma_go)
  );

  page_copy_engine u_page_copy_engine (
    .clk        (clk),
    .reset_n    (reset_n),
    .blanking   (blanking),
    .dma_go     (dma_go),
    .dma_src    (dma_src),
    .dma_dst    (dma_dst),
    .dma_len    (dma_len),
    .rd_ack     (rd_ack),
    .wr_ack     (wr_ack),
    .dma_done   (dma_done),
    .block_vga  (block_vga),
    .dma_active (dma_active),
    .rd_req     (rd_req),
    .rd_page    (rd_page),
    .rd_buf     (rd_buf),
    .wr_req     (wr_req),
    .wr_page    (wr_page),
    .wr_buf     (wr_buf)
  );

endmodule

`default_nettype wire

// ==== design/video_dma_regs.sv ====
`default_nettype none

module video_dma_regs (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                vga_stb,
  input  logic                dma_stb,
  input  logic                we,
  input  logic [1:0]          offset,
  input  soc_pkg::bus_data_t  dat_w,
  input  logic                dma_done,
  output logic                ack,
  output soc_pkg::vga_mode_t  vga_mode,
  output soc_pkg::line_base_t line_base,
  output soc_pkg::page_t      dma_src,
  output soc_pkg::page_t      dma_dst,
  output soc_pkg::page_t      dma_len,
  output logic                dma_go
);

  import soc_pkg::*;

  logic take_vga;
  logic take_dma;

  assign take_vga = vga_stb && !ack;
  assign take_dma = dma_stb && !ack && !dma_go; // stalled while a copy runs

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack <= 1'b0;
    end else begin
      ack <= take_vga || take_dma;          // single-cycle pulse
    end
  end

  // display settings
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      vga_mode  <= vga_mode_reset;
      line_base <= '0;
    end else if (take_vga && we) begin
      case (offset)
        reg_vga_mode:  vga_mode  <= dat_w[1:0];
        reg_line_base: line_base <= dat_w[11:0];
        default: ;                          // upper offsets unused
      endcase
    end
  end

  // dma settings and go/done handshake
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dma_src <= '0;
      dma_dst <= '0;
      dma_len <= '0;
      dma_go  <= 1'b0;
    end else if (dma_go && dma_done) begin
      dma_go <= 1'b0;                       // go falls a cycle after done rises
    end else if (take_dma && we) begin
      case (offset)
        reg_dma_src: dma_src <= dat_w[15:0];
        reg_dma_dst: dma_dst <= dat_w[15:0];
        reg_dma_len: dma_len <= dat_w[15:0];
        reg_dma_go:  dma_go  <= 1'b1;       // data ignored
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tb
design/soc_pkg.sv
design/bus_decoder.sv
design/main_sram.sv
design/video_dma_regs.sv
design/page_copy_engine.sv
design/soc_top.sv
tb/tb_soc_top.sv

// ==== tb/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;                       // wrong values seen
int other_errors = 0;                       // protocol or timing trouble

task automatic check_data(input string name, input soc_pkg::bus_data_t got,
                          input soc_pkg::bus_data_t exp);
  if (got !== exp) begin
    value_errors++;
    $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_page(input string name, input soc_pkg::page_t got,
                          input soc_pkg::page_t exp);
  if (got !== exp) begin
    value_errors++;
    $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    value_errors++;
    $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_mode(input string name, input soc_pkg::vga_mode_t got,
                          input soc_pkg::vga_mode_t exp);
  if (got !== exp) begin
    value_errors++;
    $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

// anything that is not a value compare
task automatic fail_note(input string msg);
  other_errors++;
  $display("ERROR %s at %0t", msg, $time);
endtask

// closing summary
task automatic print_counts();
  $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
endtask

`endif

// ==== tb/tb_soc_top.sv ====
`default_nettype none

module tb_soc_top;

  import soc_pkg::*;

  localparam int     period      = 40;
  localparam int     num_copies  = 6;
  localparam int     max_len     = 6;
  localparam int     num_xfers   = sram_words + 200 + 68 + 20 + num_copies * 6;
  localparam longint watchdog_at = longint'(num_xfers * 64 + num_copies * (max_len + 1) * 16)
                                   * period;

  logic       clk;
  logic       reset_n;
  logic       cyc;
  logic       stb;
  logic       we;
  bus_addr_t  adr;
  bus_data_t  dat_w;
  bus_data_t  dat_r;
  bus_sel_t   sel;
  logic       ack;
  logic       blanking;
  vga_mode_t  vga_mode;
  line_base_t line_base;
  logic       block_vga;
  logic       dma_active;
  logic       rd_req;
  page_t      rd_page;
  logic       rd_buf;
  logic       rd_ack;
  logic       wr_req;
  page_t      wr_page;
  logic       wr_buf;
  logic       wr_ack;

  integer     seed = 32'h4934;
  bus_data_t  sram_model [sram_words];      // reference memory
  page_t      rd_pages [$];                 // every read request seen
  logic       rd_bufs [$];
  page_t      wr_pages [$];
  logic       wr_bufs [$];
  int         wr_steps [$];                 // read index at the write's rise
  logic       blank_hold = 1'b0;            // parks blanking low around go
  int         go_epoch = 0;                 // bumped after each go write

  `include "tb_checks.svh"

  soc_top dut (
    .clk(clk), .reset_n(reset_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .sel(sel), .ack(ack), .blanking(blanking),
    .vga_mode(vga_mode), .line_base(line_base), .block_vga(block_vga),
    .dma_active(dma_active), .rd_req(rd_req), .rd_page(rd_page), .rd_buf(rd_buf),
    .rd_ack(rd_ack), .wr_req(wr_req), .wr_page(wr_page), .wr_buf(wr_buf),
    .wr_ack(wr_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = !clk;
  end

  initial begin
    #(watchdog_at);
    fail_note("watchdog expired, tests did not finish in time");
    print_counts();
    $display("TB FAILED");
    $finish;
  end

  // blanking toggles at random intervals unless parked
  initial begin
    blanking = 1'b0;
    forever begin
      repeat (3 + ({$random(seed)} % 16)) @(posedge clk);
      blanking <= blank_hold ? 1'b0 : !blanking;
    end
  end

  // read-side memory controller, acks after 1 to 4 cycles
  initial begin
    rd_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (rd_req && !rd_ack) begin
        repeat (1 + ({$random(seed)} % 4)) @(posedge clk);
        rd_ack <= 1'b1;
        do @(negedge clk); while (rd_req); // four-phase
        repeat (1 + ({$random(seed)} % 4)) @(posedge clk);
        rd_ack <= 1'b0;
      end
    end
  end

  // write-side memory controller
  initial begin
    wr_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (wr_req && !wr_ack) begin
        repeat (1 + ({$random(seed)} % 4)) @(posedge clk);
        wr_ack <= 1'b1;
        do @(negedge clk); while (wr_req);
        repeat (1 + ({$random(seed)} % 4)) @(posedge clk);
        wr_ack <= 1'b0;
      end
    end
  end

  // request monitor, sampled mid-cycle
  initial begin
    logic prev_rd;
    logic prev_wr;
    logic prev_blank;
    logic blank_seen;
    int   seen_epoch;
    prev_rd    = 1'b0;
    prev_wr    = 1'b0;
    prev_blank = 1'b0;
    blank_seen = 1'b0;
    seen_epoch = 0;
    forever begin
      @(negedge clk);
      if (seen_epoch != go_epoch) begin      // new go, forget older edges
        blank_seen = 1'b0;
        seen_epoch = go_epoch;
      end
      if (blanking && !prev_blank) blank_seen = 1'b1;
      if (rd_req && !prev_rd) begin
        if (!blank_seen) fail_note("rd_req rose before a blanking edge after go");
        if (rd_ack || wr_ack) fail_note("rd_req rose while an old ack was high");
        rd_pages.push_back(rd_page);
        rd_bufs.push_back(rd_buf);
      end
      if (wr_req && !prev_wr) begin
        if (rd_ack || wr_ack) fail_note("wr_req rose while an old ack was high");
        wr_pages.push_back(wr_page);
        wr_bufs.push_back(wr_buf);
        wr_steps.push_back(rd_pages.size() - 1); // paired read index
      end
      if (rd_req || wr_req || rd_ack || wr_ack) begin
        check_bit("block_vga", block_vga, 1'b1);
        check_bit("dma_active", dma_active, 1'b1);
      end
      prev_rd    = rd_req;
      prev_wr    = wr_req;
      prev_blank = blanking;
    end
  end

  // one Wishbone classic transfer, lat counts cycles from stb to ack
  task automatic bus_xfer(input logic wr, input bus_addr_t a, input bus_data_t d,
                          input bus_sel_t s, output bus_data_t rd, output int lat);
    int n;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= d;
    sel   <= s;
    n   = 0;
    rd  = '0;
    lat = -1;
    forever begin
      @(negedge clk);
      if (ack) begin
        rd  = dat_r;
        lat = n;
        break;
      end
      n++;
      if (n > 64) begin
        fail_note($sformatf("no ack within 64 cycles for address %h", a));
        break;
      end
    end
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  function automatic bus_addr_t dma_addr(input logic [1:0] off);
    return {win_dma, 12'h000, off, 2'b00};
  endfunction

  task automatic fill_sram();
    bus_data_t d;
    bus_data_t rd;
    int lat;
    for (int i = 0; i < sram_words; i++) begin
      d = (bus_data_t'(i) * 32'h0001_0203) ^ 32'h5a5a_0000; // whole-index pattern
      bus_xfer(1'b1, {win_sram, 5'b0, 9'(i), 2'b00}, d, 4'hf, rd, lat);
      sram_model[i] = d;
    end
  endtask

  task automatic unmapped_accesses();
    bus_data_t r;
    bus_data_t rd;
    logic [15:0] w;
    int lat;
    int idx;
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      w = r[31:16];
      if (w == win_sram || w == win_vga || w == win_dma) w = w ^ 16'h8000; // stay unmapped
      bus_xfer(i[0], {w, r[15:0]}, $random(seed), 4'hf, rd, lat);
      check_data("dat_r unmapped", rd, '0);
      if (i[0]) begin                       // same word index in sram left alone
        idx = int'(r[10:2]);
        bus_xfer(1'b0, {win_sram, 5'b0, r[10:2], 2'b00}, '0, 4'hf, rd, lat);
        check_data("dat_r sram after unmapped write", rd, sram_model[idx]);
      end
    end
    for (int i = 0; i < 4; i++) begin       // register windows read as zero
      bus_xfer(1'b0, {win_vga, 12'h000, i[1:0], 2'b00}, '0, 4'hf, rd, lat);
      check_data("dat_r vga window", rd, '0);
      bus_xfer(1'b0, dma_addr(i[1:0]), '0, 4'hf, rd, lat);
      check_data("dat_r dma window", rd, '0);
    end
    check_mode("vga_mode", vga_mode, vga_mode_reset);
    check_data("line_base", {20'h0, line_base}, '0);
  endtask

  task automatic sram_random_access();
    bus_data_t r;
    bus_data_t d;
    bus_data_t rd;
    bus_addr_t a;
    bus_sel_t  s;
    int lat;
    int idx;
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      a = {win_sram, r[15:2], 2'b00};       // bits 15..11 alias
      idx = int'(a[10:2]);
      s = r[19:16];
      d = $random(seed);
      if (r[20]) begin
        bus_xfer(1'b1, a, d, s, rd, lat);
        for (int b = 0; b < 4; b++) begin
          if (s[b]) sram_model[idx][8*b +: 8] = d[8*b +: 8];
        end
      end else begin
        bus_xfer(1'b0, a, '0, s, rd, lat);
        check_data("dat_r sram", rd, sram_model[idx]);
      end
      check_bit("sram ack after one cycle", lat == 1, 1'b1);
    end
  endtask

  task automatic display_register_writes();
    bus_data_t  d;
    bus_data_t  rd;
    logic [1:0] off;
    vga_mode_t  exp_mode;
    line_base_t exp_base;
    int lat;
    exp_mode = vga_mode_reset;
    exp_base = '0;
    for (int i = 0; i < 20; i++) begin
      d   = $random(seed);
      off = 2'(i % 3);                      // offset 2 must change nothing
      bus_xfer(1'b1, {win_vga, 12'h000, off, 2'b00}, d, 4'hf, rd, lat);
      if (off == reg_vga_mode) exp_mode = d[1:0];
      if (off == reg_line_base) exp_base = d[11:0];
      check_mode("vga_mode", vga_mode, exp_mode);
      check_data("line_base", {20'h0, line_base}, {20'h0, exp_base});
    end
  endtask

  // compares the requests since base indices with the copy rules
  task automatic verify_copy(input page_t src, input page_t dst, input int len,
                             input int rd_base, input int wr_base);
    int k;
    check_data("read count", rd_pages.size() - rd_base, len + 1);
    check_data("write count", wr_pages.size() - wr_base, len);
    for (int i = rd_base; i < rd_pages.size(); i++) begin
      k = i - rd_base;
      check_page("rd_page", rd_pages[i], src + 16'(k));
      check_bit("rd_buf", rd_bufs[i], k[0]);
    end
    for (int i = wr_base; i < wr_pages.size(); i++) begin
      k = i - wr_base + 1;                  // writes start at step 1
      check_page("wr_page", wr_pages[i], dst + 16'(k - 1));
      check_bit("wr_buf", wr_bufs[i], !k[0]);
      check_data("write step", wr_steps[i] - rd_base, k);
    end
  endtask

  task automatic run_copy(input page_t src, input page_t dst, input int len,
                          input logic write_len, input logic stall, input int next_len);
    bus_data_t rd;
    int lat;
    int rd_base;
    int wr_base;
    bus_xfer(1'b1, dma_addr(reg_dma_src), {16'h0, src}, 4'hf, rd, lat);
    bus_xfer(1'b1, dma_addr(reg_dma_dst), {16'h0, dst}, 4'hf, rd, lat);
    if (write_len) bus_xfer(1'b1, dma_addr(reg_dma_len), len, 4'hf, rd, lat);
    rd_base = rd_pages.size();
    wr_base = wr_pages.size();
    blank_hold = 1'b1;
    @(negedge clk);
    while (blanking) @(negedge clk);
    repeat (4) @(posedge clk);              // synchroniser settles low
    bus_xfer(1'b1, dma_addr(reg_dma_go), $random(seed), 4'hf, rd, lat);
    go_epoch++;
    blank_hold = 1'b0;
    while (!dma_active) @(negedge clk);
    if (stall) begin
      bus_xfer(1'b1, dma_addr(reg_dma_len), next_len, 4'hf, rd, lat);
      check_bit("dma_active at stalled ack", dma_active, 1'b0);
    end else begin
      while (dma_active) @(negedge clk);
    end
    verify_copy(src, dst, len, rd_base, wr_base);
  endtask

  initial begin
    int len;
    int next_len;
    reset_n = 1'b0;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    adr     = '0;
    dat_w   = '0;
    sel     = '0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_bit("ack", ack, 1'b0);
    check_mode("vga_mode", vga_mode, vga_mode_reset);
    check_data("line_base", {20'h0, line_base}, '0);
    check_bit("block_vga", block_vga, 1'b0);
    check_bit("dma_active", dma_active, 1'b0);
    check_bit("rd_req", rd_req, 1'b0);
    check_bit("wr_req", wr_req, 1'b0);
    fill_sram();
    unmapped_accesses();
    sram_random_access();
    display_register_writes();
    for (int c = 0; c < num_copies; c++) begin
      if (c == 3) begin                     // short copy, len rewritten under stall
        len      = {$random(seed)} % 4;
        next_len = {$random(seed)} % (max_len + 1);
        run_copy(16'($random(seed)), 16'($random(seed)), len, 1'b1, 1'b1, next_len);
      end else if (c == 4) begin
        run_copy(16'($random(seed)), 16'($random(seed)), next_len, 1'b0, 1'b0, 0);
      end else begin
        len = {$random(seed)} % (max_len + 1);
        run_copy(16'($random(seed)), 16'($random(seed)), len, 1'b1, 1'b0, 0);
      end
    end
    repeat (4) @(posedge clk);
    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
